/* Makefile */
VERILATOR ?= verilator
TOP       ?= idStageTb
FILELIST  ?= idStage.f
OBJDIR    ?= obj_dir
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST)) rtl/idCfg.svh
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf $(OBJDIR)

/* idStage.f */
+incdir+rtl
rtl/idPkg.sv
rtl/idExIf.sv
rtl/immGen.sv
rtl/opDecode.sv
rtl/branchUnit.sv
rtl/idExReg.sv
rtl/idStage.sv
testbench/idStageProps.sv
testbench/idStageTb.sv

/* rtl/branchUnit.sv */
`timescale 1ns/1ps
`include "idCfg.svh"

module branchUnit (
    input  idPkg::word_t    pc_i,
    input  idPkg::word_t    reg1Data_i,
    input  idPkg::word_t    reg2Data_i,
    input  idPkg::word_t    imm_i,
    input  idPkg::word_t    exMemWbData_i,
    input  idPkg::regAddr_t reg1Addr_i,
    input  idPkg::regAddr_t reg2Addr_i,
    input  idPkg::regAddr_t idExRd_i,
    input  idPkg::regAddr_t exMemRd_i,
    input  logic [2:0]      funct3_i,
    input  logic            idExRegWe_i,
    input  logic            exMemRegWe_i,
    input  logic            isBranch_i,
    input  logic            isJal_i,
    input  logic            isJalr_i,
    output logic            branch_o,
    output logic            stallReq_o,
    output idPkg::word_t    branchTarget_o
);

    idPkg::word_t rs1Val;
    idPkg::word_t rs2Val;
    idPkg::word_t jalrSum;
    logic         exMemHit;
    logic         rs1Hazard;
    logic         rs2Hazard;
    logic         cond;
    logic         taken;

    // EX/MEM result bypasses the register file read
    assign exMemHit = exMemRegWe_i && exMemRd_i != '0;
    assign rs1Val   = (exMemHit && exMemRd_i == reg1Addr_i) ? exMemWbData_i : reg1Data_i;
    assign rs2Val   = (exMemHit && exMemRd_i == reg2Addr_i) ? exMemWbData_i : reg2Data_i;

    // ID/EX result not computed yet
    assign rs1Hazard  = idExRegWe_i && idExRd_i != '0 && idExRd_i == reg1Addr_i;
    assign rs2Hazard  = idExRegWe_i && idExRd_i != '0 && idExRd_i == reg2Addr_i;
    assign stallReq_o = (isBranch_i && (rs1Hazard || rs2Hazard)) || (isJalr_i && rs1Hazard);

    always_comb begin
        case (funct3_i)
            `F3_BEQ:  cond = rs1Val == rs2Val;
            `F3_BNE:  cond = rs1Val != rs2Val;
            `F3_BLT:  cond = $signed(rs1Val) < $signed(rs2Val);
            `F3_BGE:  cond = $signed(rs1Val) >= $signed(rs2Val);
            `F3_BLTU: cond = rs1Val < rs2Val;
            `F3_BGEU: cond = rs1Val >= rs2Val;
            default:  cond = 1'b0; // reserved encodings
        endcase
    end

    assign taken    = !stallReq_o && ((isBranch_i && cond) || isJal_i || isJalr_i);
    assign branch_o = taken;
    assign jalrSum  = rs1Val + imm_i;

    always_comb begin
        if (!taken) begin
            branchTarget_o = '0;
        end else if (isJalr_i) begin
            branchTarget_o = {jalrSum[31:1], 1'b0}; // lsb cleared
        end else begin
            branchTarget_o = pc_i + imm_i;
        end
    end

endmodule

/* rtl/idCfg.svh */
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define LINK_OFFSET 32'd4           // return address is pc + 4
`define NOP_INST    32'h0000_0000

// major opcodes
`define OP_R        7'b0110011
`define OP_IMM      7'b0010011
`define OP_LOAD     7'b0000011
`define OP_JALR     7'b1100111
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111

`define FUNCT7_ALT  7'b0100000      // sub / sra

// branch conditions
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`endif

/* rtl/idExIf.sv */
`timescale 1ns/1ps

interface idExIf;

    idPkg::aluSel_t  aluSel;
    idPkg::word_t    src1;
    idPkg::word_t    src2;
    idPkg::regAddr_t rd;
    logic            regWe;
    idPkg::memCtl_t  loadCtl;
    idPkg::memCtl_t  storeCtl;
    idPkg::word_t    storeData;
    logic            valid;         // low for nop or unknown opcode

    modport source (
        output aluSel, src1, src2, rd, regWe,
        output loadCtl, storeCtl, storeData, valid
    );

    modport sink (
        input aluSel, src1, src2, rd, regWe,
        input loadCtl, storeCtl, storeData, valid
    );

endinterface

/* rtl/idExReg.sv */
`timescale 1ns/1ps

module idExReg (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            stall_i,
    idExIf.sink             bundle,
    output idPkg::aluSel_t  aluSel_o,
    output idPkg::word_t    src1_o,
    output idPkg::word_t    src2_o,
    output idPkg::word_t    storeData_o,
    output idPkg::regAddr_t rd_o,
    output logic            regWe_o,
    output idPkg::memCtl_t  loadCtl_o,
    output idPkg::memCtl_t  storeCtl_o
);

    logic bubble;

    assign bubble = reset_i || stall_i || !bundle.valid;

    always_ff @(posedge clk) begin
        if (bubble) begin
            aluSel_o    <= idPkg::aluNop;
            src1_o      <= '0;
            src2_o      <= '0;
            storeData_o <= '0;
            rd_o        <= '0;
            regWe_o     <= 1'b0;
            loadCtl_o   <= '0;
            storeCtl_o  <= '0;
        end else begin
            aluSel_o    <= bundle.aluSel;
            src1_o      <= bundle.src1;
            src2_o      <= bundle.src2;
            storeData_o <= bundle.storeData;
            rd_o        <= bundle.rd;
            regWe_o     <= bundle.regWe;
            loadCtl_o   <= bundle.loadCtl;
            storeCtl_o  <= bundle.storeCtl;
        end
    end

endmodule

/* rtl/idPkg.sv */
`include "idCfg.svh"

package idPkg;

    // data word or address
    typedef logic [`XLEN-1:0] word_t;

    // register index
    typedef logic [`REG_ADDR_W-1:0] regAddr_t;

    // {active, funct3}, zero means no access
    typedef logic [3:0] memCtl_t;

    typedef enum logic [3:0] {
        aluNop,
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluSel_t;

endpackage

/* rtl/idStage.sv */
`timescale 1ns/1ps

module idStage (
    input  logic            clk,
    input  logic            reset_i,
    input  idPkg::word_t    pc_i,
    input  idPkg::word_t    inst_i,
    input  idPkg::word_t    reg1Data_i,
    input  idPkg::word_t    reg2Data_i,
    input  idPkg::regAddr_t idExRd_i,
    input  logic            idExRegWe_i,
    input  idPkg::regAddr_t exMemRd_i,
    input  logic            exMemRegWe_i,
    input  idPkg::word_t    exMemWbData_i,
    output idPkg::regAddr_t reg1Addr_o,
    output idPkg::regAddr_t reg2Addr_o,
    output logic            reg1Re_o,
    output logic            reg2Re_o,
    output logic            branch_o,
    output idPkg::word_t    branchTarget_o,
    output logic            stallReq_o,
    output idPkg::aluSel_t  aluSel_o,
    output idPkg::word_t    src1_o,
    output idPkg::word_t    src2_o,
    output idPkg::regAddr_t rd_o,
    output logic            regWe_o,
    output idPkg::memCtl_t  loadCtl_o,
    output idPkg::memCtl_t  storeCtl_o,
    output idPkg::word_t    storeData_o
);

    idPkg::word_t imm;
    logic         isBranch;
    logic         isJal;
    logic         isJalr;

    idExIf idEx ();

    immGen immGen_i (
        .inst_i (inst_i),
        .imm_o  (imm)
    );

    opDecode opDecode_i (
        .pc_i       (pc_i),
        .inst_i     (inst_i),
        .reg1Data_i (reg1Data_i),
        .reg2Data_i (reg2Data_i),
        .imm_i      (imm),
        .reg1Addr_o (reg1Addr_o),
        .reg2Addr_o (reg2Addr_o),
        .reg1Re_o   (reg1Re_o),
        .reg2Re_o   (reg2Re_o),
        .isBranch_o (isBranch),
        .isJal_o    (isJal),
        .isJalr_o   (isJalr),
        .bundle     (idEx.source)
    );

    branchUnit branchUnit_i (
        .pc_i           (pc_i),
        .reg1Data_i     (reg1Data_i),
        .reg2Data_i     (reg2Data_i),
        .imm_i          (imm),
        .exMemWbData_i  (exMemWbData_i),
        .reg1Addr_i     (reg1Addr_o),
        .reg2Addr_i     (reg2Addr_o),
        .idExRd_i       (idExRd_i),
        .exMemRd_i      (exMemRd_i),
        .funct3_i       (inst_i[14:12]),
        .idExRegWe_i    (idExRegWe_i),
        .exMemRegWe_i   (exMemRegWe_i),
        .isBranch_i     (isBranch),
        .isJal_i        (isJal),
        .isJalr_i       (isJalr),
        .branch_o       (branch_o),
        .stallReq_o     (stallReq_o),
        .branchTarget_o (branchTarget_o)
    );

    idExReg idExReg_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .stall_i     (stallReq_o),
        .bundle      (idEx.sink),
        .aluSel_o    (aluSel_o),
        .src1_o      (src1_o),
        .src2_o      (src2_o),
        .storeData_o (storeData_o),
        .rd_o        (rd_o),
        .regWe_o     (regWe_o),
        .loadCtl_o   (loadCtl_o),
        .storeCtl_o  (storeCtl_o)
    );

endmodule

/* rtl/immGen.sv */
`timescale 1ns/1ps
`include "idCfg.svh"

module immGen (
    input  idPkg::word_t inst_i,
    output idPkg::word_t imm_o
);

    logic [6:0] opcode;

    assign opcode = inst_i[6:0];

    always_comb begin
        case (opcode)
            `OP_IMM,
            `OP_LOAD,
            `OP_JALR: begin // I format
                imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
            end
            `OP_STORE: begin // S format
                imm_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            end
            `OP_BRANCH: begin // B format, halfword aligned
                imm_o = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
            end
            `OP_LUI,
            `OP_AUIPC: begin
                imm_o = {inst_i[31:12], 12'b0};
            end
            `OP_JAL: begin // J format
                imm_o = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0; // R-type and unknown
            end
        endcase
    end

endmodule

/* rtl/opDecode.sv */
`timescale 1ns/1ps
`include "idCfg.svh"

module opDecode (
    input  idPkg::word_t    pc_i,
    input  idPkg::word_t    inst_i,
    input  idPkg::word_t    reg1Data_i,
    input  idPkg::word_t    reg2Data_i,
    input  idPkg::word_t    imm_i,
    output idPkg::regAddr_t reg1Addr_o,
    output idPkg::regAddr_t reg2Addr_o,
    output logic            reg1Re_o,
    output logic            reg2Re_o,
    output logic            isBranch_o,
    output logic            isJal_o,
    output logic            isJalr_o,
    idExIf.source           bundle
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    idPkg::regAddr_t rs1;
    idPkg::regAddr_t rs2;
    idPkg::regAddr_t rd;
    logic            altOp;
    idPkg::aluSel_t  aluFunc;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign rd     = inst_i[11:7];
    assign altOp  = funct7 == `FUNCT7_ALT;

    // ALU function shared by R-type and I-arithmetic
    always_comb begin
        case (funct3)
            3'b000:  aluFunc = (opcode == `OP_R && altOp) ? idPkg::aluSub : idPkg::aluAdd;
            3'b001:  aluFunc = idPkg::aluSll;
            3'b010:  aluFunc = idPkg::aluSlt;
            3'b011:  aluFunc = idPkg::aluSltu;
            3'b100:  aluFunc = idPkg::aluXor;
            3'b101:  aluFunc = altOp ? idPkg::aluSra : idPkg::aluSrl; // srai carries funct7 too
            3'b110:  aluFunc = idPkg::aluOr;
            default: aluFunc = idPkg::aluAnd;
        endcase
    end

    always_comb begin
        reg1Addr_o       = '0;
        reg2Addr_o       = '0;
        reg1Re_o         = 1'b0;
        reg2Re_o         = 1'b0;
        isBranch_o       = 1'b0;
        isJal_o          = 1'b0;
        isJalr_o         = 1'b0;
        bundle.aluSel    = idPkg::aluNop;
        bundle.src1      = '0;
        bundle.src2      = '0;
        bundle.rd        = '0;
        bundle.regWe     = 1'b0;
        bundle.loadCtl   = '0;
        bundle.storeCtl  = '0;
        bundle.storeData = '0;
        bundle.valid     = inst_i != `NOP_INST;
        case (opcode)
            `OP_R, `OP_IMM, `OP_LOAD: begin
                reg1Addr_o    = rs1;
                reg1Re_o      = 1'b1;
                bundle.aluSel = aluFunc;
                bundle.src1   = reg1Data_i;
                bundle.src2   = imm_i;
                bundle.rd     = rd;
                bundle.regWe  = 1'b1;
                if (opcode == `OP_R) begin
                    reg2Addr_o  = rs2;
                    reg2Re_o    = 1'b1;
                    bundle.src2 = reg2Data_i;
                end
                if (opcode == `OP_LOAD) begin
                    bundle.aluSel  = idPkg::aluAdd; // address = rs1 + imm
                    bundle.loadCtl = {1'b1, funct3};
                end
            end
            `OP_STORE: begin
                reg1Addr_o       = rs1;
                reg2Addr_o       = rs2;
                reg1Re_o         = 1'b1;
                reg2Re_o         = 1'b1;
                bundle.aluSel    = idPkg::aluAdd;
                bundle.src1      = reg1Data_i;
                bundle.src2      = imm_i;
                bundle.storeCtl  = {1'b1, funct3};
                bundle.storeData = reg2Data_i;
            end
            `OP_BRANCH: begin // resolved here, nothing for EX
                reg1Addr_o = rs1;
                reg2Addr_o = rs2;
                reg1Re_o   = 1'b1;
                reg2Re_o   = 1'b1;
                isBranch_o = 1'b1;
            end
            `OP_JAL, `OP_JALR: begin
                isJal_o       = opcode == `OP_JAL;
                isJalr_o      = opcode == `OP_JALR;
                reg1Addr_o    = isJalr_o ? rs1 : '0;
                reg1Re_o      = isJalr_o;
                bundle.aluSel = idPkg::aluAdd; // link value pc + 4
                bundle.src1   = pc_i;
                bundle.src2   = `LINK_OFFSET;
                bundle.rd     = rd;
                bundle.regWe  = 1'b1;
            end
            `OP_LUI, `OP_AUIPC: begin
                bundle.aluSel = idPkg::aluAdd;
                bundle.src1   = (opcode == `OP_AUIPC) ? pc_i : '0;
                bundle.src2   = imm_i;
                bundle.rd     = rd;
                bundle.regWe  = 1'b1;
            end
            default: begin
                bundle.valid = 1'b0; // unknown opcode
            end
        endcase
    end

endmodule

/* testbench/idStageProps.sv */
`timescale 1ns/1ps

module idStageProps (
    input logic clk,
    input logic reset_i,
    input logic stallReq_i,
    input logic branch_i,
    input logic regWe_i
);

    resetGivesBubble: assert property (@(posedge clk) reset_i |=> !regWe_i)
        else $error("regWe_o high one cycle after reset");

    // stalled instruction must not reach EX
    stallGivesBubble: assert property (@(posedge clk) stallReq_i |=> !regWe_i)
        else $error("regWe_o high one cycle after a stall request");

    stallBlocksBranch: assert property (@(posedge clk) stallReq_i |-> !branch_i)
        else $error("branch_o high during a stall request");

endmodule

bind idStage idStageProps idStageProps_i (
    .clk        (clk),
    .reset_i    (reset_i),
    .stallReq_i (stallReq_o),
    .branch_i   (branch_o),
    .regWe_i    (regWe_o)
);

/* testbench/idStageTb.sv */
`timescale 1ns/1ps
`include "idCfg.svh"

module idStageTb;

    logic            clk;
    logic            reset_i;
    idPkg::word_t    pc_i;
    idPkg::word_t    inst_i;
    idPkg::word_t    reg1Data_i;
    idPkg::word_t    reg2Data_i;
    idPkg::regAddr_t idExRd_i;
    logic            idExRegWe_i;
    idPkg::regAddr_t exMemRd_i;
    logic            exMemRegWe_i;
    idPkg::word_t    exMemWbData_i;
    idPkg::regAddr_t reg1Addr_o;
    idPkg::regAddr_t reg2Addr_o;
    logic            reg1Re_o;
    logic            reg2Re_o;
    logic            branch_o;
    idPkg::word_t    branchTarget_o;
    logic            stallReq_o;
    idPkg::aluSel_t  aluSel_o;
    idPkg::word_t    src1_o;
    idPkg::word_t    src2_o;
    idPkg::regAddr_t rd_o;
    logic            regWe_o;
    idPkg::memCtl_t  loadCtl_o;
    idPkg::memCtl_t  storeCtl_o;
    idPkg::word_t    storeData_o;

    logic [31:0]     lcgState;
    int              errors;
    int              testsRun;
    int              testsFailed;
    logic            resetReq;      // upstream control values for the next present
    logic            fwdWe;
    idPkg::regAddr_t fwdRd;
    idPkg::word_t    fwdData;
    logic            hazWe;
    idPkg::regAddr_t hazRd;

    idStage idStage_i (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic idPkg::word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // I format with R-type passing {funct7, rs2} as the upper field
    function automatic idPkg::word_t encodeI(logic [11:0] hi, idPkg::regAddr_t rs1,
                                             logic [2:0] f3, idPkg::regAddr_t rd,
                                             logic [6:0] op);
        return {hi, rs1, f3, rd, op};
    endfunction

    function automatic idPkg::word_t encodeS(logic [11:0] imm, idPkg::regAddr_t rs2,
                                             idPkg::regAddr_t rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OP_STORE};
    endfunction

    function automatic idPkg::word_t encodeB(logic [12:0] imm, idPkg::regAddr_t rs2,
                                             idPkg::regAddr_t rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    function automatic idPkg::word_t encodeU(logic [19:0] imm, idPkg::regAddr_t rd,
                                             logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic idPkg::word_t encodeJ(logic [20:0] imm, idPkg::regAddr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
    endfunction

    // RV32I operation select
    function automatic idPkg::aluSel_t expectedAlu(bit isR, logic [2:0] f3, logic [6:0] f7);
        case (f3)
            3'd0:    return (isR && f7 == `FUNCT7_ALT) ? idPkg::aluSub : idPkg::aluAdd;
            3'd1:    return idPkg::aluSll;
            3'd2:    return idPkg::aluSlt;
            3'd3:    return idPkg::aluSltu;
            3'd4:    return idPkg::aluXor;
            3'd5:    return (f7 == `FUNCT7_ALT) ? idPkg::aluSra : idPkg::aluSrl;
            3'd6:    return idPkg::aluOr;
            default: return idPkg::aluAnd;
        endcase
    endfunction

    function automatic logic branchCond(logic [2:0] f3, idPkg::word_t a, idPkg::word_t b);
        case (f3)
            `F3_BEQ:  return a == b;
            `F3_BNE:  return a != b;
            `F3_BLT:  return $signed(a) < $signed(b);
            `F3_BGE:  return $signed(a) >= $signed(b);
            `F3_BLTU: return a < b;
            `F3_BGEU: return a >= b;
            default:  return 1'b0;
        endcase
    endfunction

    task automatic mismatch(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        $display("ERROR %s: expected %h, actual %h", name, expVal, actVal);
        errors++;
    endtask

    // inputs change on the rising edge and outputs are read at the falling edge
    task automatic present(input idPkg::word_t pc, input idPkg::word_t inst,
                           input idPkg::word_t r1, input idPkg::word_t r2);
        @(posedge clk);
        reset_i       <= resetReq;
        pc_i          <= pc;
        inst_i        <= inst;
        reg1Data_i    <= r1;
        reg2Data_i    <= r2;
        exMemRegWe_i  <= fwdWe;
        exMemRd_i     <= fwdRd;
        exMemWbData_i <= fwdData;
        idExRegWe_i   <= hazWe;
        idExRd_i      <= hazRd;
        @(negedge clk);
    endtask

    // ID/EX outputs one edge later
    task automatic checkStage(input string name, input idPkg::aluSel_t alu,
                              input idPkg::word_t s1, input idPkg::word_t s2,
                              input idPkg::regAddr_t rd, input logic we,
                              input idPkg::memCtl_t ld, input idPkg::memCtl_t st,
                              input idPkg::word_t sd);
        @(negedge clk);
        if (aluSel_o !== alu) mismatch({name, " aluSel"}, 32'(alu), 32'(aluSel_o));
        if (src1_o !== s1) mismatch({name, " src1"}, s1, src1_o);
        if (src2_o !== s2) mismatch({name, " src2"}, s2, src2_o);
        if (rd_o !== rd) mismatch({name, " rd"}, 32'(rd), 32'(rd_o));
        if (regWe_o !== we) mismatch({name, " regWe"}, 32'(we), 32'(regWe_o));
        if (loadCtl_o !== ld) mismatch({name, " loadCtl"}, 32'(ld), 32'(loadCtl_o));
        if (storeCtl_o !== st) mismatch({name, " storeCtl"}, 32'(st), 32'(storeCtl_o));
        if (storeData_o !== sd) mismatch({name, " storeData"}, sd, storeData_o);
    endtask

    task automatic waitNoStall(input string where);
        int  n;
        bit  clear;
        clear = 1'b0;
        for (n = 0; n < 8 && !clear; n++) begin
            @(negedge clk);
            clear = !stallReq_o;
        end
        if (!clear) begin
            $display("timeout: stall request still high %s", where);
            $display("sim failed");
            $finish;
        end
    endtask

    task automatic finishTest(input string name, input int start);
        testsRun++;
        if (errors != start) begin
            testsFailed++;
            $display("test %s: %0d errors", name, errors - start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic arithTest();
        int              i;
        int              start;
        logic [31:0]     rnd;
        idPkg::word_t    pc;
        idPkg::word_t    r1;
        idPkg::word_t    r2;
        logic [11:0]     hi;
        logic [6:0]      f7;
        logic [2:0]      f3;
        bit              isR;
        start = errors;
        for (i = 0; i < 16; i++) begin
            rnd = nextRand();
            r1  = nextRand();
            r2  = nextRand();
            pc  = {rnd[31:2], 2'b00};
            isR = i[0];
            f3  = (i < 4) ? (i[1] ? 3'b101 : 3'b000) : rnd[14:12]; // first four fixed
            f7  = (i < 4 || rnd[3]) ? `FUNCT7_ALT : 7'h00; // sub, sra and srai
            hi  = (isR || f3[1:0] == 2'b01) ? {f7, rnd[24:20]} : rnd[31:20];
            present(pc, encodeI(hi, rnd[19:15], f3, rnd[11:7], isR ? `OP_R : `OP_IMM),
                    r1, r2);
            if (reg1Re_o !== 1'b1) mismatch("arith reg1Re", 32'd1, 32'(reg1Re_o));
            if (reg2Re_o !== isR) mismatch("arith reg2Re", 32'(isR), 32'(reg2Re_o));
            if (reg1Addr_o !== rnd[19:15]) mismatch("arith reg1Addr", 32'(rnd[19:15]),
                                                    32'(reg1Addr_o));
            if (isR && reg2Addr_o !== rnd[24:20]) mismatch("arith reg2Addr", 32'(rnd[24:20]),
                                                           32'(reg2Addr_o));
            checkStage("arith", expectedAlu(isR, f3, hi[11:5]), r1,
                       isR ? r2 : sext12(hi), rnd[11:7], 1'b1, 4'h0, 4'h0, 32'h0);
        end
        finishTest("arith", start);
    endtask

    task automatic memTest();
        int              i;
        int              start;
        logic [31:0]     rnd;
        idPkg::word_t    pc;
        idPkg::word_t    r1;
        idPkg::word_t    r2;
        idPkg::word_t    inst;
        idPkg::word_t    s1;
        idPkg::word_t    s2;
        idPkg::word_t    sd;
        idPkg::regAddr_t rd;
        logic            we;
        idPkg::memCtl_t  ld;
        idPkg::memCtl_t  st;
        start = errors;
        for (i = 0; i < 12; i++) begin
            rnd = nextRand();
            r1  = nextRand();
            r2  = nextRand();
            pc  = {r2[15:2], 18'h0} | {rnd[17:2], 2'b00};
            s1  = r1;
            s2  = sext12(rnd[31:20]);
            sd  = 32'h0;
            rd  = rnd[11:7];
            we  = 1'b1;
            ld  = 4'h0;
            st  = 4'h0;
            case (i % 4)
                0: begin
                    inst = encodeI(rnd[31:20], rnd[19:15], rnd[14:12], rd, `OP_LOAD);
                    ld   = {1'b1, rnd[14:12]};
                end
                1: begin
                    inst = encodeS(rnd[31:20], rnd[24:20], rnd[19:15], rnd[14:12]);
                    st   = {1'b1, rnd[14:12]};
                    sd   = r2;
                    rd   = 5'd0;
                    we   = 1'b0;
                end
                2: begin
                    inst = encodeU(rnd[31:12], rd, `OP_LUI);
                    s1   = 32'h0;
                    s2   = {rnd[31:12], 12'h000};
                end
                default: begin
                    inst = encodeU(rnd[31:12], rd, `OP_AUIPC);
                    s1   = pc;
                    s2   = {rnd[31:12], 12'h000};
                end
            endcase
            present(pc, inst, r1, r2);
            checkStage("mem", idPkg::aluAdd, s1, s2, rd, we, ld, st, sd);
        end
        finishTest("mem", start);
    endtask

    task automatic branchTest();
        int              i;
        int              k;
        int              start;
        logic [31:0]     rnd;
        idPkg::word_t    pc;
        idPkg::word_t    r1;
        idPkg::word_t    r2;
        idPkg::word_t    a;
        idPkg::word_t    b;
        idPkg::word_t    tgt;
        idPkg::regAddr_t rs1;
        idPkg::regAddr_t rs2;
        logic [2:0]      f3;
        logic [12:0]     imm;
        logic            taken;
        start = errors;
        for (i = 0; i < 24; i++) begin
            k       = i % 6;
            f3      = 3'(k < 2 ? k : k + 2);
            rnd     = nextRand();
            rs1     = {1'b0, rnd[18:15]} | 5'd1;
            rs2     = rs1 + 5'd16;
            imm     = {rnd[31:20], 1'b0};
            pc      = {16'h0, rnd[15:2], 2'b00};
            r1      = nextRand();
            r2      = (i >= 12) ? r1 : nextRand(); // equal operands in the second half
            fwdWe   = ((i / 6) % 2) == 1;
            fwdRd   = rnd[0] ? rs1 : rs2;
            fwdData = nextRand();
            a       = (fwdWe && fwdRd == rs1) ? fwdData : r1;
            b       = (fwdWe && fwdRd == rs2) ? fwdData : r2;
            taken   = branchCond(f3, a, b);
            tgt     = taken ? pc + {{19{imm[12]}}, imm} : 32'h0;
            present(pc, encodeB(imm, rs2, rs1, f3), r1, r2);
            if (branch_o !== taken) mismatch("branch taken", 32'(taken), 32'(branch_o));
            if (branchTarget_o !== tgt) mismatch("branch target", tgt, branchTarget_o);
            if (stallReq_o !== 1'b0) mismatch("branch stall", 32'd0, 32'(stallReq_o));
        end
        fwdWe = 1'b0;
        finishTest("branch", start);
    endtask

    task automatic jumpTest();
        int              i;
        int              start;
        logic [31:0]     rnd;
        idPkg::word_t    pc;
        idPkg::word_t    r1;
        idPkg::word_t    inst;
        idPkg::word_t    tgt;
        logic [20:0]     imm;
        start = errors;
        for (i = 0; i < 8; i++) begin
            rnd = nextRand();
            r1  = nextRand();
            pc  = {12'h0, rnd[19:2], 2'b00};
            imm = {rnd[31:12], 1'b0};
            if (i[0] == 1'b0) begin
                inst = encodeJ(imm, rnd[11:7]);
                tgt  = pc + {{11{imm[20]}}, imm};
            end else begin
                inst = encodeI(rnd[31:20], rnd[19:15], 3'b000, rnd[11:7], `OP_JALR);
                tgt  = (r1 + sext12(rnd[31:20])) & ~32'h1;
            end
            present(pc, inst, r1, 32'h0);
            if (branch_o !== 1'b1) mismatch("jump taken", 32'd1, 32'(branch_o));
            if (branchTarget_o !== tgt) mismatch("jump target", tgt, branchTarget_o);
            checkStage("jump", idPkg::aluAdd, pc, 32'd4, rnd[11:7], 1'b1, 4'h0, 4'h0, 32'h0);
        end
        finishTest("jump", start);
    endtask

    task automatic stallTest();
        int start;
        start = errors;
        hazWe = 1'b1;
        hazRd = 5'd7;
        present(32'h100, encodeB(13'd16, 5'd9, 5'd7, `F3_BEQ), 32'h5, 32'h5);
        if (stallReq_o !== 1'b1) mismatch("stall branch req", 32'd1, 32'(stallReq_o));
        if (branch_o !== 1'b0) mismatch("stall branch taken", 32'd0, 32'(branch_o));
        checkStage("stall branch", idPkg::aluNop, 32'h0, 32'h0, 5'd0, 1'b0, 4'h0, 4'h0, 32'h0);
        // a jalr writes rd so its bubble is visible
        present(32'h200, encodeI(12'h010, 5'd7, 3'b000, 5'd1, `OP_JALR), 32'h40, 32'h0);
        if (stallReq_o !== 1'b1) mismatch("stall jalr req", 32'd1, 32'(stallReq_o));
        checkStage("stall jalr", idPkg::aluNop, 32'h0, 32'h0, 5'd0, 1'b0, 4'h0, 4'h0, 32'h0);
        hazRd = 5'd0;
        present(32'h300, encodeB(13'd16, 5'd9, 5'd0, `F3_BEQ), 32'h5, 32'h5);
        if (stallReq_o !== 1'b0) mismatch("stall x0 req", 32'd0, 32'(stallReq_o));
        if (branch_o !== 1'b1) mismatch("stall x0 taken", 32'd1, 32'(branch_o));
        hazWe = 1'b0;
        present(32'h304, encodeI(12'h001, 5'd2, 3'b000, 5'd3, `OP_IMM), 32'h0, 32'h0);
        waitNoStall("after hazard cleared");
        finishTest("stall", start);
    endtask

    task automatic bubbleTest();
        int start;
        start = errors;
        resetReq = 1'b1;
        present(32'h400, encodeI(12'h123, 5'd4, 3'b000, 5'd5, `OP_IMM), 32'h9, 32'h0);
        checkStage("bubble reset", idPkg::aluNop, 32'h0, 32'h0, 5'd0, 1'b0, 4'h0, 4'h0, 32'h0);
        resetReq = 1'b0;
        present(32'h404, `NOP_INST, 32'h9, 32'h9);
        checkStage("bubble nop", idPkg::aluNop, 32'h0, 32'h0, 5'd0, 1'b0, 4'h0, 4'h0, 32'h0);
        present(32'h408, 32'h0000_0FFF, 32'h9, 32'h9); // opcode 7f is not RV32I
        checkStage("bubble unknown", idPkg::aluNop, 32'h0, 32'h0, 5'd0, 1'b0, 4'h0, 4'h0,
                   32'h0);
        finishTest("bubble", start);
    endtask

    initial begin
        int n;
        lcgState      = 32'd53263;
        errors        = 0;
        testsRun      = 0;
        testsFailed   = 0;
        resetReq      = 1'b0;
        fwdWe         = 1'b0;
        fwdRd         = 5'd0;
        fwdData       = 32'h0;
        hazWe         = 1'b0;
        hazRd         = 5'd0;
        clk           = 1'b0;
        reset_i       = 1'b1;
        pc_i          = 32'h0;
        inst_i        = 32'h0;
        reg1Data_i    = 32'h0;
        reg2Data_i    = 32'h0;
        idExRd_i      = 5'd0;
        idExRegWe_i   = 1'b0;
        exMemRd_i     = 5'd0;
        exMemRegWe_i  = 1'b0;
        exMemWbData_i = 32'h0;
        for (n = 0; n < 2; n++) begin
            @(posedge clk);
        end
        reset_i <= 1'b0;
        waitNoStall("after reset");
        arithTest();
        memTest();
        branchTest();
        jumpTest();
        stallTest();
        bubbleTest();
        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
